/* hdl/ic_pkg.sv */
`default_nettype none

package ic_pkg;

    // cache geometry
    localparam int WAY_CNT    = 2;
    localparam int SET_CNT    = 64;
    localparam int LINE_WORDS = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    // address split is tag [31:10], index [9:4], word [3:2]
    typedef logic [21:0] tag_t;
    typedef logic [5:0]  index_t;
    typedef logic [1:0]  word_sel_t;
    typedef logic [1:0]  way_vec_t;
    typedef logic [0:0]  way_t;
    typedef logic [1:0]  cacheop_t;

    // maintenance operation codes
    localparam cacheop_t CACHEOP_INDEX_INV = 2'b01;
    localparam cacheop_t CACHEOP_HIT_INV   = 2'b10;

    typedef enum logic [2:0] {
        ST_LOOKUP,
        ST_INV_READ,
        ST_INV_WRITE,
        ST_BUS_REQ,
        ST_FILL,
        ST_REFILL_RESP
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/ic_tag_array.sv */
`timescale 1ns/1ns
`default_nettype none

module ic_tag_array (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rd_en_i,
    input  ic_pkg::index_t   index_i,
    input  ic_pkg::tag_t     tag_i,
    input  ic_pkg::way_vec_t wr_en_i,
    input  logic             wr_valid_i,
    output ic_pkg::way_vec_t hit_o
);

    ic_pkg::tag_t tag_mem [ic_pkg::WAY_CNT][ic_pkg::SET_CNT];
    logic [ic_pkg::SET_CNT-1:0] valid_q [ic_pkg::WAY_CNT];

    // valid bits per way and set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < ic_pkg::WAY_CNT; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < ic_pkg::WAY_CNT; w++) begin
                if (wr_en_i[w]) begin
                    valid_q[w][index_i] <= wr_valid_i;
                end
            end
        end
    end

    // tag storage
    always_ff @(posedge clk) begin
        for (int w = 0; w < ic_pkg::WAY_CNT; w++) begin
            if (wr_en_i[w]) begin
                tag_mem[w][index_i] <= tag_i;
            end
        end
    end

    // compare against the incoming tag, result seen next cycle
    // hit_o holds while no read is issued
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_o <= '0;
        end else if (rd_en_i) begin
            for (int w = 0; w < ic_pkg::WAY_CNT; w++) begin
                hit_o[w] <= valid_q[w][index_i] && (tag_mem[w][index_i] == tag_i);
            end
        end
    end

    // refill only follows a miss, so a line never sits in two ways
    hit_onehot_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(hit_o)
    );

endmodule

`default_nettype wire

/* hdl/ic_data_array.sv */
`timescale 1ns/1ns
`default_nettype none

module ic_data_array (
    input  logic              clk,
    input  logic              rd_en_i,
    input  ic_pkg::index_t    index_i,
    input  logic              rd_pair_i,
    input  logic              wr_en_i,
    input  ic_pkg::way_t      wr_way_i,
    input  ic_pkg::word_sel_t wr_word_i,
    input  ic_pkg::word_t     wr_data_i,
    output ic_pkg::word_t     rd_way0_inst0_o,
    output ic_pkg::word_t     rd_way0_inst1_o,
    output ic_pkg::word_t     rd_way1_inst0_o,
    output ic_pkg::word_t     rd_way1_inst1_o
);

    // one word per entry, entry = {set, word}
    ic_pkg::word_t mem [ic_pkg::WAY_CNT][ic_pkg::SET_CNT * ic_pkg::LINE_WORDS];

    // refill writes a single word per beat
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_way_i][{index_i, wr_word_i}] <= wr_data_i;
        end
    end

    // even/odd pair of both ways, picked later by the hit vector
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_way0_inst0_o <= mem[0][{index_i, rd_pair_i, 1'b0}];
            rd_way0_inst1_o <= mem[0][{index_i, rd_pair_i, 1'b1}];
            rd_way1_inst0_o <= mem[1][{index_i, rd_pair_i, 1'b0}];
            rd_way1_inst1_o <= mem[1][{index_i, rd_pair_i, 1'b1}];
        end
    end

endmodule

`default_nettype wire

/* hdl/ic_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module ic_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_valid_i,
    input  ic_pkg::addr_t     fetch_pc_i,
    output logic              ready_o,
    output logic              resp_valid_o,
    output ic_pkg::addr_t     resp_pc_o,
    output ic_pkg::word_t     resp_inst0_o,
    output ic_pkg::word_t     resp_inst1_o,
    input  logic              resp_ready_i,
    input  logic              cacheop_valid_i,
    input  ic_pkg::cacheop_t  cacheop_i,
    input  ic_pkg::addr_t     cacheop_addr_i,
    output logic              cacheop_ready_o,
    output logic              bus_req_valid_o,
    output ic_pkg::addr_t     bus_req_addr_o,
    input  logic              bus_req_ready_i,
    input  logic              bus_data_valid_i,
    input  ic_pkg::word_t     bus_data_i,
    input  logic              bus_data_last_i,
    output logic              arr_rd_en_o,
    output ic_pkg::index_t    arr_index_o,
    output ic_pkg::tag_t      arr_tag_o,
    output logic              arr_rd_pair_o,
    output ic_pkg::way_vec_t  tag_wr_en_o,
    output logic              tag_wr_valid_o,
    output logic              data_wr_en_o,
    output ic_pkg::way_t      data_wr_way_o,
    output ic_pkg::word_sel_t data_wr_word_o,
    output ic_pkg::word_t     data_wr_data_o,
    input  ic_pkg::way_vec_t  hit_i,
    input  ic_pkg::word_t     rd_way0_inst0_i,
    input  ic_pkg::word_t     rd_way0_inst1_i,
    input  ic_pkg::word_t     rd_way1_inst0_i,
    input  ic_pkg::word_t     rd_way1_inst1_i
);

    ic_pkg::ctrl_state_t state_q, state_d;
    logic                lk_valid_q;
    ic_pkg::addr_t       lk_pc_q;
    ic_pkg::cacheop_t    op_q;
    ic_pkg::addr_t       op_addr_q;
    ic_pkg::word_sel_t   beat_q;
    ic_pkg::word_t       fill_inst0_q, fill_inst1_q;
    logic [7:0]          lfsr_q;
    ic_pkg::way_t        victim_way;
    logic                lk_hit, lk_miss, fetch_fire, cacheop_fire;

    assign lk_hit  = lk_valid_q && (|hit_i);
    assign lk_miss = lk_valid_q && !(|hit_i);

    // output slot frees when empty or drained this cycle; cache ops win
    assign ready_o = (state_q == ic_pkg::ST_LOOKUP) && !cacheop_valid_i &&
                     (!lk_valid_q || (lk_hit && resp_ready_i));
    assign cacheop_ready_o = (state_q == ic_pkg::ST_LOOKUP) && !lk_valid_q;
    assign fetch_fire      = fetch_valid_i && ready_o;
    assign cacheop_fire    = cacheop_valid_i && cacheop_ready_o;
    assign victim_way      = lfsr_q[0];

    always_comb begin
        state_d = state_q;
        case (state_q)
            ic_pkg::ST_LOOKUP: begin
                if (cacheop_fire) begin
                    state_d = ic_pkg::ST_INV_READ;
                end else if (lk_miss) begin
                    state_d = ic_pkg::ST_BUS_REQ;
                end
            end
            ic_pkg::ST_INV_READ:  state_d = ic_pkg::ST_INV_WRITE;
            ic_pkg::ST_INV_WRITE: state_d = ic_pkg::ST_LOOKUP;
            ic_pkg::ST_BUS_REQ: begin
                if (bus_req_ready_i) begin
                    state_d = ic_pkg::ST_FILL;
                end
            end
            ic_pkg::ST_FILL: begin
                if (bus_data_valid_i && bus_data_last_i) begin
                    state_d = ic_pkg::ST_REFILL_RESP;
                end
            end
            ic_pkg::ST_REFILL_RESP: begin
                if (resp_ready_i) begin
                    state_d = ic_pkg::ST_LOOKUP;
                end
            end
            default: state_d = ic_pkg::ST_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= ic_pkg::ST_LOOKUP;
            lk_valid_q <= 1'b0;
            beat_q     <= '0;
            lfsr_q     <= 8'h5a;
        end else begin
            state_q <= state_d;
            if (state_q == ic_pkg::ST_LOOKUP) begin
                if (lk_miss) begin
                    lk_valid_q <= 1'b0;
                end else if (!lk_valid_q || resp_ready_i) begin
                    lk_valid_q <= fetch_fire;
                end
            end
            if (state_q == ic_pkg::ST_BUS_REQ) begin
                beat_q <= '0;
            end else if (data_wr_en_o) begin
                beat_q <= beat_q + 2'd1;
            end
            // victim moves on once per refill, x^8+x^6+x^5+x^4+1
            if (data_wr_en_o && bus_data_last_i) begin
                lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            lk_pc_q <= fetch_pc_i;
        end
        if (cacheop_fire) begin
            op_q      <= cacheop_i;
            op_addr_q <= cacheop_addr_i;
        end
        // keep the two beats of the requested half line
        if (data_wr_en_o && (beat_q[1] == lk_pc_q[3])) begin
            if (beat_q[0]) begin
                fill_inst1_q <= bus_data_i;
            end else begin
                fill_inst0_q <= bus_data_i;
            end
        end
    end

    // array address source follows the state
    always_comb begin
        arr_rd_en_o    = fetch_fire || (state_q == ic_pkg::ST_INV_READ);
        arr_rd_pair_o  = fetch_pc_i[3];
        arr_index_o    = lk_pc_q[9:4];
        arr_tag_o      = lk_pc_q[31:10];
        tag_wr_en_o    = '0;
        tag_wr_valid_o = (state_q == ic_pkg::ST_FILL);
        if (state_q == ic_pkg::ST_LOOKUP) begin
            arr_index_o = fetch_pc_i[9:4];
            arr_tag_o   = fetch_pc_i[31:10];
        end else if (state_q == ic_pkg::ST_INV_READ || state_q == ic_pkg::ST_INV_WRITE) begin
            arr_index_o = op_addr_q[9:4];
            arr_tag_o   = op_addr_q[31:10];
        end
        if (state_q == ic_pkg::ST_INV_WRITE) begin
            if (op_q == ic_pkg::CACHEOP_INDEX_INV) begin
                tag_wr_en_o = '1;
            end else if (op_q == ic_pkg::CACHEOP_HIT_INV) begin
                tag_wr_en_o = hit_i;
            end
        end else if (data_wr_en_o && bus_data_last_i) begin
            tag_wr_en_o[victim_way] = 1'b1;
        end
    end

    assign data_wr_en_o   = (state_q == ic_pkg::ST_FILL) && bus_data_valid_i;
    assign data_wr_way_o  = victim_way;
    assign data_wr_word_o = beat_q;
    assign data_wr_data_o = bus_data_i;

    assign bus_req_valid_o = (state_q == ic_pkg::ST_BUS_REQ);
    assign bus_req_addr_o  = {lk_pc_q[31:4], 4'b0000};

    // hit data goes straight from the array registers
    always_comb begin
        resp_pc_o    = lk_pc_q;
        resp_valid_o = (state_q == ic_pkg::ST_LOOKUP) && lk_hit;
        resp_inst0_o = hit_i[1] ? rd_way1_inst0_i : rd_way0_inst0_i;
        resp_inst1_o = hit_i[1] ? rd_way1_inst1_i : rd_way0_inst1_i;
        if (state_q == ic_pkg::ST_REFILL_RESP) begin
            resp_valid_o = 1'b1;
            resp_inst0_o = fill_inst0_q;
            resp_inst1_o = fill_inst1_q;
        end
    end

    bus_req_stable_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o && $stable(bus_req_addr_o)
    );

    // arrays and lookup stage must all freeze under back-pressure
    resp_stable_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_pc_o) &&
            $stable(resp_inst0_o) && $stable(resp_inst1_o)
    );

endmodule

`default_nettype wire

/* hdl/ic_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ic_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_valid_i,
    input  ic_pkg::addr_t    fetch_pc_i,
    output logic             ready_o,
    output logic             resp_valid_o,
    output ic_pkg::addr_t    resp_pc_o,
    output ic_pkg::word_t    resp_inst0_o,
    output ic_pkg::word_t    resp_inst1_o,
    input  logic             resp_ready_i,
    input  logic             cacheop_valid_i,
    input  ic_pkg::cacheop_t cacheop_i,
    input  ic_pkg::addr_t    cacheop_addr_i,
    output logic             cacheop_ready_o,
    output logic             bus_req_valid_o,
    output ic_pkg::addr_t    bus_req_addr_o,
    input  logic             bus_req_ready_i,
    input  logic             bus_data_valid_i,
    input  ic_pkg::word_t    bus_data_i,
    input  logic             bus_data_last_i
);

    logic              arr_rd_en, arr_rd_pair;
    ic_pkg::index_t    arr_index;
    ic_pkg::tag_t      arr_tag;
    ic_pkg::way_vec_t  tag_wr_en, hit;
    logic              tag_wr_valid;
    logic              data_wr_en;
    ic_pkg::way_t      data_wr_way;
    ic_pkg::word_sel_t data_wr_word;
    ic_pkg::word_t     data_wr_data;
    ic_pkg::word_t     way0_inst0, way0_inst1, way1_inst0, way1_inst1;

    // tag and data arrays share one address from the controller
    ic_tag_array u_tag (
        .clk(clk), .rst_n(rst_n), .rd_en_i(arr_rd_en), .index_i(arr_index),
        .tag_i(arr_tag), .wr_en_i(tag_wr_en), .wr_valid_i(tag_wr_valid), .hit_o(hit)
    );

    ic_data_array u_data (
        .clk(clk), .rd_en_i(arr_rd_en), .index_i(arr_index), .rd_pair_i(arr_rd_pair),
        .wr_en_i(data_wr_en), .wr_way_i(data_wr_way), .wr_word_i(data_wr_word),
        .wr_data_i(data_wr_data), .rd_way0_inst0_o(way0_inst0), .rd_way0_inst1_o(way0_inst1),
        .rd_way1_inst0_o(way1_inst0), .rd_way1_inst1_o(way1_inst1)
    );

    ic_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .fetch_valid_i(fetch_valid_i), .fetch_pc_i(fetch_pc_i),
        .ready_o(ready_o), .resp_valid_o(resp_valid_o), .resp_pc_o(resp_pc_o),
        .resp_inst0_o(resp_inst0_o), .resp_inst1_o(resp_inst1_o), .resp_ready_i(resp_ready_i),
        .cacheop_valid_i(cacheop_valid_i), .cacheop_i(cacheop_i),
        .cacheop_addr_i(cacheop_addr_i), .cacheop_ready_o(cacheop_ready_o),
        .bus_req_valid_o(bus_req_valid_o), .bus_req_addr_o(bus_req_addr_o),
        .bus_req_ready_i(bus_req_ready_i), .bus_data_valid_i(bus_data_valid_i),
        .bus_data_i(bus_data_i), .bus_data_last_i(bus_data_last_i),
        .arr_rd_en_o(arr_rd_en), .arr_index_o(arr_index), .arr_tag_o(arr_tag),
        .arr_rd_pair_o(arr_rd_pair), .tag_wr_en_o(tag_wr_en), .tag_wr_valid_o(tag_wr_valid),
        .data_wr_en_o(data_wr_en), .data_wr_way_o(data_wr_way),
        .data_wr_word_o(data_wr_word), .data_wr_data_o(data_wr_data), .hit_i(hit),
        .rd_way0_inst0_i(way0_inst0), .rd_way0_inst1_i(way0_inst1),
        .rd_way1_inst0_i(way1_inst0), .rd_way1_inst1_i(way1_inst1)
    );

endmodule

`default_nettype wire

/* tests/ic_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module ic_mem_model (
    input  logic          clk,
    input  logic          rst_n,
    input  logic [2:0]    delay_i,
    input  logic          bus_req_valid_i,
    input  ic_pkg::addr_t bus_req_addr_i,
    output logic          bus_req_ready_o,
    output logic          bus_data_valid_o,
    output ic_pkg::word_t bus_data_o,
    output logic          bus_data_last_o
);

    typedef enum logic [1:0] {M_IDLE, M_GRANT, M_TAKE, M_BEATS} mem_phase_t;

    mem_phase_t    phase;
    logic [2:0]    wait_cnt;
    logic [1:0]    beat;
    ic_pkg::addr_t line_addr;

    initial begin
        bus_req_ready_o  = 1'b0;
        bus_data_valid_o = 1'b0;
        bus_data_o       = '0;
        bus_data_last_o  = 1'b0;
    end

    always @(posedge clk) begin
        bus_req_ready_o  <= 1'b0;
        bus_data_valid_o <= 1'b0;
        bus_data_last_o  <= 1'b0;
        if (!rst_n) begin
            phase <= M_IDLE;
        end else begin
            case (phase)
                M_IDLE: begin
                    if (bus_req_valid_i) begin
                        wait_cnt <= delay_i;
                        phase    <= M_GRANT;
                    end
                end
                // grant once the random wait has run out
                M_GRANT: begin
                    if (wait_cnt != 3'd0) begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end else begin
                        bus_req_ready_o <= 1'b1;
                        phase           <= M_TAKE;
                    end
                end
                M_TAKE: begin
                    line_addr <= bus_req_addr_i;
                    beat      <= 2'd0;
                    wait_cnt  <= delay_i;
                    phase     <= M_BEATS;
                end
                default: begin
                    if (wait_cnt != 3'd0) begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end else begin
                        // word value is its byte address scrambled
                        bus_data_valid_o <= 1'b1;
                        bus_data_o       <= {line_addr[31:4], beat, 2'b00} ^ 32'hc3a5_0f1e;
                        bus_data_last_o  <= (beat == 2'd3);
                        beat             <= beat + 2'd1;
                        wait_cnt         <= delay_i;
                        if (beat == 2'd3) begin
                            phase <= M_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tests/ic_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ic_tb;

    localparam int NUM_FETCH   = 400;
    localparam int CYCLE_LIMIT = 40000;

    logic             clk;
    logic             rst_n;
    logic             fetch_valid_i;
    ic_pkg::addr_t    fetch_pc_i;
    logic             ready_o;
    logic             resp_valid_o;
    ic_pkg::addr_t    resp_pc_o;
    ic_pkg::word_t    resp_inst0_o;
    ic_pkg::word_t    resp_inst1_o;
    logic             resp_ready_i;
    logic             cacheop_valid_i;
    ic_pkg::cacheop_t cacheop_i;
    ic_pkg::addr_t    cacheop_addr_i;
    logic             cacheop_ready_o;
    logic             bus_req_valid_o;
    ic_pkg::addr_t    bus_req_addr_o;
    logic             bus_req_ready_i;
    logic             bus_data_valid_i;
    ic_pkg::word_t    bus_data_i;
    logic             bus_data_last_i;
    logic [2:0]       mem_delay;

    logic [31:0]      lfsr_q;
    int               cycle, mismatches, failures, offered, accepted, last_line;
    int               front_reqs, beat_cnt, last_beat_cyc;
    logic             front_seen, fetch_took, op_took, hold_q;
    ic_pkg::addr_t    held_pc;
    ic_pkg::word_t    held_inst0, held_inst1;
    // lines known resident and lines known absent among the 16 used
    logic [15:0]      known_res, known_abs;
    // outstanding fetches with kind {timed, expect miss, expect hit}
    ic_pkg::addr_t    pend_pc[$];
    logic [2:0]       pend_kind[$];
    int               pend_acc[$];

    ic_top dut0 (
        .clk(clk), .rst_n(rst_n), .fetch_valid_i(fetch_valid_i), .fetch_pc_i(fetch_pc_i),
        .ready_o(ready_o), .resp_valid_o(resp_valid_o), .resp_pc_o(resp_pc_o),
        .resp_inst0_o(resp_inst0_o), .resp_inst1_o(resp_inst1_o), .resp_ready_i(resp_ready_i),
        .cacheop_valid_i(cacheop_valid_i), .cacheop_i(cacheop_i),
        .cacheop_addr_i(cacheop_addr_i), .cacheop_ready_o(cacheop_ready_o),
        .bus_req_valid_o(bus_req_valid_o), .bus_req_addr_o(bus_req_addr_o),
        .bus_req_ready_i(bus_req_ready_i), .bus_data_valid_i(bus_data_valid_i),
        .bus_data_i(bus_data_i), .bus_data_last_i(bus_data_last_i)
    );

    ic_mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .delay_i(mem_delay), .bus_req_valid_i(bus_req_valid_o),
        .bus_req_addr_i(bus_req_addr_o), .bus_req_ready_o(bus_req_ready_i),
        .bus_data_valid_o(bus_data_valid_i), .bus_data_o(bus_data_i),
        .bus_data_last_o(bus_data_last_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int nbits);
        int r;
        r = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = (r << 1) | int'(lfsr_q[0]);
        end
        return r;
    endfunction

    // sets 9, 25, 41, 57 with four tags each
    function automatic ic_pkg::addr_t line_addr(input int line);
        logic [3:0] sel;
        sel = 4'(line);
        return {20'h0_3a1, sel, 4'b1001, 4'b0000};
    endfunction

    function automatic int line_of(input ic_pkg::addr_t a);
        return int'(a[11:8]);
    endfunction

    function automatic ic_pkg::word_t mem_word(input ic_pkg::addr_t a);
        return a ^ 32'hc3a5_0f1e;
    endfunction

    task automatic check_word(input ic_pkg::word_t got, input ic_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input ic_pkg::addr_t got, input ic_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        failures++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // everything seen here is what the next rising edge takes
    task automatic sample_cycle();
        logic       resp_fire, req_fire;
        logic [2:0] kind;
        int         line;
        @(negedge clk);
        cycle++;
        resp_fire  = resp_valid_o && resp_ready_i;
        req_fire   = bus_req_valid_o && bus_req_ready_i;
        op_took    = cacheop_valid_i && cacheop_ready_o;
        fetch_took = fetch_valid_i && ready_o;
        if (hold_q) begin
            check_count(int'(resp_valid_o), 1, "resp_valid_o under back-pressure");
            check_addr(resp_pc_o, held_pc, "resp_pc_o under back-pressure");
            check_word(resp_inst0_o, held_inst0, "resp_inst0_o under back-pressure");
            check_word(resp_inst1_o, held_inst1, "resp_inst1_o under back-pressure");
        end
        hold_q     = resp_valid_o && !resp_ready_i;
        held_pc    = resp_pc_o;
        held_inst0 = resp_inst0_o;
        held_inst1 = resp_inst1_o;
        if (hold_q) begin
            check_count(int'(ready_o), 0, "ready_o under back-pressure");
        end
        if (req_fire) begin
            if (pend_pc.size() == 0) begin
                report_error("bus request with no fetch outstanding");
            end else begin
                check_addr(bus_req_addr_o, {pend_pc[0][31:4], 4'b0000}, "bus request address");
                check_count(front_reqs, 0, "earlier bus requests for this fetch");
            end
            front_reqs++;
            beat_cnt = 0;
        end
        if (bus_data_valid_i) begin
            beat_cnt++;
            if (bus_data_last_i) begin
                last_beat_cyc = cycle;
                if (pend_pc.size() != 0) begin
                    // victim way is hidden so only the new line is certain
                    known_res = '0;
                    known_res[line_of(pend_pc[0])] = 1'b1;
                    known_abs[line_of(pend_pc[0])] = 1'b0;
                end
            end
        end
        if (resp_valid_o && pend_pc.size() == 0) begin
            report_error("response valid with no fetch outstanding");
        end else if (resp_valid_o && !front_seen) begin
            front_seen = 1'b1;
            kind = pend_kind[0];
            if (kind[2]) begin
                check_count(cycle - pend_acc[0], 1, "cycles from accept to hit response");
            end
            // a miss answers only once all four beats are taken
            if (front_reqs != 0) begin
                check_count(beat_cnt, 4, "beats before the miss response");
                check_count(cycle - last_beat_cyc, 1, "cycles from last beat to miss response");
            end
        end
        if (resp_fire && pend_pc.size() != 0) begin
            kind = pend_kind[0];
            check_addr(resp_pc_o, pend_pc[0], "resp_pc_o");
            check_word(resp_inst0_o, mem_word(pend_pc[0]), "resp_inst0_o");
            check_word(resp_inst1_o, mem_word(pend_pc[0] + 32'd4), "resp_inst1_o");
            if (kind[0]) begin
                check_count(front_reqs, 0, "bus requests for a resident line");
            end
            if (kind[1]) begin
                check_count(front_reqs, 1, "bus requests for an invalidated line");
            end
            pend_pc.delete(0);
            pend_kind.delete(0);
            pend_acc.delete(0);
            front_reqs = 0;
            front_seen = 1'b0;
        end
        if (op_took) begin
            for (int l = 0; l < 16; l++) begin
                if ((cacheop_i == ic_pkg::CACHEOP_INDEX_INV &&
                     (l % 4) == (line_of(cacheop_addr_i) % 4)) ||
                    (cacheop_i == ic_pkg::CACHEOP_HIT_INV && l == line_of(cacheop_addr_i))) begin
                    known_res[l] = 1'b0;
                    known_abs[l] = 1'b1;
                end
            end
        end
        if (fetch_took) begin
            line = line_of(fetch_pc_i);
            kind = {known_res[line] && (pend_pc.size() == 0), known_abs[line], known_res[line]};
            pend_pc.push_back(fetch_pc_i);
            pend_kind.push_back(kind);
            pend_acc.push_back(cycle);
            accepted++;
        end
    endtask

    task automatic drive_cycle();
        int line;
        @(posedge clk);
        resp_ready_i <= (rand_bits(2) != 0);
        mem_delay    <= 3'(rand_bits(3) % 6);
        if (op_took) begin
            cacheop_valid_i <= 1'b0;
        end
        if ((op_took || !cacheop_valid_i) && offered < NUM_FETCH && rand_bits(4) == 0) begin
            cacheop_valid_i <= 1'b1;
            cacheop_i       <= (rand_bits(1) != 0) ? ic_pkg::CACHEOP_INDEX_INV
                                                   : ic_pkg::CACHEOP_HIT_INV;
            cacheop_addr_i  <= line_addr(rand_bits(4));
        end
        if (fetch_took) begin
            fetch_valid_i <= 1'b0;
        end
        // idle gap one time in four and often the same line again
        if ((fetch_took || !fetch_valid_i) && offered < NUM_FETCH && rand_bits(2) != 0) begin
            line = (rand_bits(1) != 0) ? last_line : rand_bits(4);
            last_line = line;
            fetch_valid_i <= 1'b1;
            fetch_pc_i    <= line_addr(line) | ic_pkg::addr_t'(rand_bits(1) << 3);
            offered++;
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        fetch_valid_i   = 1'b0;
        fetch_pc_i      = '0;
        resp_ready_i    = 1'b0;
        cacheop_valid_i = 1'b0;
        cacheop_i       = '0;
        cacheop_addr_i  = '0;
        mem_delay       = '0;
        lfsr_q          = 32'ha08e_9cdd;
        cycle           = 0;
        mismatches      = 0;
        failures        = 0;
        offered         = 0;
        accepted        = 0;
        last_line       = 0;
        front_reqs      = 0;
        beat_cnt        = 0;
        last_beat_cyc   = 0;
        front_seen      = 1'b0;
        fetch_took      = 1'b0;
        op_took         = 1'b0;
        hold_q          = 1'b0;
        known_res       = '0;
        known_abs       = '1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_count(int'(resp_valid_o), 0, "resp_valid_o after reset");
        check_count(int'(bus_req_valid_o), 0, "bus_req_valid_o after reset");
        check_count(int'(ready_o), 1, "ready_o after reset");
        check_count(int'(cacheop_ready_o), 1, "cacheop_ready_o after reset");
        while (!(accepted == NUM_FETCH && pend_pc.size() == 0 && !cacheop_valid_i) &&
               cycle < CYCLE_LIMIT) begin
            drive_cycle();
            sample_cycle();
        end
        if (cycle >= CYCLE_LIMIT) begin
            report_error("timeout, fetches did not all complete within the cycle limit");
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hdl/ic_pkg.sv
hdl/ic_tag_array.sv
hdl/ic_data_array.sv
hdl/ic_ctrl.sv
hdl/ic_top.sv
tests/ic_mem_model.sv
tests/ic_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module ic_tb -f all.f -o ic_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ic_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
    exit 1
fi
exit 0
